// ==== Makefile ====
# Verilator build and run for the ALU step testbench

SOURCES := $(wildcard source/*.sv) $(wildcard testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vtb_alu_step: alu_step.f $(SOURCES)
	verilator --binary --timing --top-module tb_alu_step -f alu_step.f -o Vtb_alu_step

run: obj_dir/Vtb_alu_step
	obj_dir/Vtb_alu_step | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== alu_step.f ====
source/alu_pkg.sv
source/alu_op_if.sv
source/alu_cmd_in.sv
source/alu_slice.sv
source/carry_lookahead.sv
source/alu_function.sv
source/alu_result_out.sv
source/alu_step_top.sv
testbench/alu_checker.sv
testbench/tb_alu_step.sv

// ==== source/alu_cmd_in.sv ====
// ALU command input side
// Four-phase req/ack receiver with a one-entry command buffer that
// feeds the function block until the command is taken

`timescale 1ns/1ps
`default_nettype none

module alu_cmd_in import alu_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   input  logic     cmd_req,
   input  alu_cmd_t cmd_data,
   output logic     cmd_ack,
   alu_op_if.source op
);

   // held: request pending, buffer still occupied
   typedef enum logic [1:0] {st_idle, st_held, st_wait_low} hs_state_t;

   hs_state_t state;
   alu_cmd_t  cmd_buf;
   logic      buf_valid;
   logic      capture;

   // Only accept into an empty buffer, never mid-handshake
   assign capture = cmd_req && !buf_valid && (state != st_wait_low);

   always_ff @(posedge clk) begin
      if (rst) begin
         state     <= st_idle;
         buf_valid <= 1'b0;
      end else begin
         case (state)
            st_idle, st_held: begin
               if (capture)
                  state <= st_wait_low;
               else if (cmd_req)
                  state <= st_held;
               else
                  state <= st_idle;
            end
            st_wait_low: begin
               if (!cmd_req)
                  state <= st_idle;
            end
            default: state <= st_idle;
         endcase

         if (capture)
            buf_valid <= 1'b1;
         else if (op.take)
            buf_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (capture)
         cmd_buf <= cmd_data;
   end

   assign cmd_ack  = (state == st_wait_low);
   assign op.cmd   = cmd_buf;
   assign op.valid = buf_valid;

endmodule

`default_nettype wire

// ==== source/alu_function.sv ====
// ALU carry and function control
// Forces add/sub/pass for multiply, divide and jump, drives eight slices
// through a two-level lookahead tree and registers the shaped result

`timescale 1ns/1ps
`default_nettype none

module alu_function import alu_pkg::*; (
   input  logic     clk,
   input  logic     rst,
   alu_op_if.sink   op,
   output alu_res_t res,
   output logic     res_valid,
   input  logic     res_ready
);

   alu_cmd_t             cmd;
   logic                 div_pos_last, div_add_cond, div_sub_cond, mul_nop;
   logic                 alu_add, alu_sub;
   logic [3:0]           alu_fn;
   logic                 alu_mode, cin0;
   logic [alu_width-1:0] sum, word;
   logic [alu_slices-1:0] sx, sy, scin;
   logic [2:0]           lo_cout_n, hi_cout_n, top_cout_n;
   logic                 xx0, yy0, xx1, yy1;
   logic                 carry_out;
   osel_t                osel;

   assign cmd = op.cmd;

   ////////////////////////////////////////////////////////////////////////////
   // Function forcing

   assign div_pos_last = cmd.q[0] | cmd.ir.fn[3];
   assign div_add_cond = cmd.is_div & (cmd.ir.fn[2] | ~div_pos_last);
   assign div_sub_cond = cmd.is_div & div_pos_last;
   assign mul_nop      = cmd.is_mul & ~cmd.q[0];

   assign alu_add = (div_add_cond & ~cmd.a[alu_width-1]) | (div_sub_cond & cmd.a[alu_width-1])
                  | cmd.is_mul;
   assign alu_sub = mul_nop | (div_sub_cond & ~cmd.a[alu_width-1])
                  | (div_add_cond & cmd.a[alu_width-1]) | cmd.is_jump;

   // Both forced means pass A
   always_comb begin
      case ({alu_sub, alu_add})
         2'b00:   {alu_fn, alu_mode, cin0} = {cmd.ir.fn[0], cmd.ir.fn[1], ~cmd.ir.fn[3],
                                              ~cmd.ir.fn[2], ~cmd.ir.mode_n, cmd.ir.carry_in};
         2'b01:   {alu_fn, alu_mode, cin0} = {4'b1001, 1'b0, 1'b0};
         2'b10:   {alu_fn, alu_mode, cin0} = {4'b0110, 1'b0, ~cmd.is_jump};
         default: {alu_fn, alu_mode, cin0} = {4'b1111, 1'b1, 1'b1};
      endcase
   end

   ////////////////////////////////////////////////////////////////////////////
   // Slices and lookahead tree

   for (genvar i = 0; i < alu_slices; i++) begin : g_slice
      alu_slice u_slice (
         .a(cmd.a[4*i +: 4]), .b(cmd.m[4*i +: 4]), .s(alu_fn), .mode(alu_mode),
         .cin(scin[i]), .f(sum[4*i +: 4]), .x(sx[i]), .y(sy[i])
      );
   end

   carry_lookahead u_cla_lo (.x(sx[3:0]), .y(sy[3:0]), .cin_n(~cin0),
                             .cout_n(lo_cout_n), .xout(xx0), .yout(yy0));
   carry_lookahead u_cla_hi (.x(sx[7:4]), .y(sy[7:4]), .cin_n(top_cout_n[0]),
                             .cout_n(hi_cout_n), .xout(xx1), .yout(yy1));
   carry_lookahead u_cla_top (.x({2'b00, xx1, xx0}), .y({2'b00, yy1, yy0}), .cin_n(~cin0),
                              .cout_n(top_cout_n), .xout(), .yout());

   assign scin      = {~hi_cout_n, ~top_cout_n[0], ~lo_cout_n, cin0};
   assign carry_out = ~top_cout_n[1];

   // Output select, plain sum unless this is an ALU instruction
   assign osel = cmd.is_alu ? osel_t'(cmd.ir.osel_bits) : osel_alu;

   always_comb begin
      case (osel)
         osel_left:   word = {sum[alu_width-2:0], 1'b0};
         osel_right:  word = {carry_out, sum[alu_width-1:1]};
         osel_qshift: word = {sum[0], cmd.q[alu_width-1:1]};
         default:     word = sum;
      endcase
   end

   assign op.take = op.valid & (~res_valid | res_ready);

   always_ff @(posedge clk) begin
      if (rst)
         res_valid <= 1'b0;
      else if (op.take)
         res_valid <= 1'b1;
      else if (res_ready)
         res_valid <= 1'b0;
   end

   always_ff @(posedge clk) begin
      if (op.take)
         res <= '{word: word, carry_out: carry_out};
   end

endmodule

`default_nettype wire

// ==== source/alu_op_if.sv ====
// Command channel from the input buffer into the function block
// Source holds cmd and valid, sink pulses take when it latches

`timescale 1ns/1ps
`default_nettype none

interface alu_op_if import alu_pkg::*; ();

   alu_cmd_t cmd;
   logic     valid;
   logic     take;

   // Buffer side
   modport source (
      output cmd,
      output valid,
      input  take
   );

   // Function block side
   modport sink (
      input  cmd,
      input  valid,
      output take
   );

endinterface

`default_nettype wire

// ==== source/alu_pkg.sv ====
// ALU step package
// Word and slice sizes, microinstruction fields, output select codes,
// and the command and result types shared across the datapath

package alu_pkg;

   localparam int alu_width  = 32;
   localparam int alu_slices = 8;

   // Low fourteen microinstruction bits, msb first
   typedef struct packed {
      logic [1:0] osel_bits;   // 13..12
      logic [3:0] spare;       // 11..8
      logic       mode_n;      // 7
      logic [3:0] fn;          // 6..3, bit 6 doubles as divide first step
      logic       carry_in;    // 2
      logic [1:0] low;         // 1..0
   } ir_low_t;

   typedef enum logic [1:0] {
      osel_alu    = 2'd0,
      osel_left   = 2'd1,
      osel_right  = 2'd2,
      osel_qshift = 2'd3
   } osel_t;

   typedef struct packed {
      logic [alu_width-1:0] a;
      logic [alu_width-1:0] m;
      logic [alu_width-1:0] q;
      ir_low_t              ir;
      logic                 is_alu;
      logic                 is_jump;
      logic                 is_mul;
      logic                 is_div;
   } alu_cmd_t;

   typedef struct packed {
      logic [alu_width-1:0] word;
      logic                 carry_out;
   } alu_res_t;

endpackage

// ==== source/alu_result_out.sv ====
// ALU result output side
// Holds one result and offers it by four-phase req/ack

`timescale 1ns/1ps
`default_nettype none

module alu_result_out import alu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  alu_res_t             res,
   input  logic                 res_valid,
   output logic                 res_ready,
   output logic                 res_req,
   input  logic                 res_ack,
   output logic [alu_width-1:0] res_word,
   output logic                 res_carry
);

   typedef enum logic [1:0] {st_empty, st_req, st_wait_low} out_state_t;

   out_state_t state;
   logic       accept;

   assign accept = res_valid && (state == st_empty);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= st_empty;
      end else begin
         case (state)
            st_empty:    if (accept) state <= st_req;
            st_req:      if (res_ack) state <= st_wait_low;
            st_wait_low: if (!res_ack) state <= st_empty;
            default:     state <= st_empty;
         endcase
      end
   end

   // Result register
   always_ff @(posedge clk) begin
      if (accept) begin
         res_word  <= res.word;
         res_carry <= res.carry_out;
      end
   end

   assign res_ready = (state == st_empty);
   assign res_req   = (state == st_req);

endmodule

`default_nettype wire

// ==== source/alu_slice.sv ====
// 4-bit ALU slice, 74181 function table with active-high data
// Logic functions when mode is high, arithmetic with carry-in otherwise,
// plus group propagate (x) and generate (y) for the lookahead tree

`timescale 1ns/1ps
`default_nettype none

module alu_slice (
   input  logic [3:0] a,
   input  logic [3:0] b,
   input  logic [3:0] s,
   input  logic       mode,
   input  logic       cin,
   output logic [3:0] f,
   output logic       x,
   output logic       y
);

   logic [3:0] pt;
   logic [3:0] gt;
   logic [3:0] c;

   // First gate level of the 74181, selected by s
   // Arithmetic result is pt plus gt plus cin, and gt is a subset of pt
   assign pt = a | (b & {4{s[0]}}) | (~b & {4{s[1]}});
   assign gt = (a & ~b & {4{s[2]}}) | (a & b & {4{s[3]}});

   // Internal carries, unused in logic mode
   always_comb begin
      c[0] = cin;
      for (int i = 0; i < 3; i++) begin
         c[i+1] = gt[i] | (pt[i] & c[i]);
      end
   end

   // Logic mode behaves as if every internal carry were forced
   assign f = mode ? ~(pt ^ gt) : (pt ^ gt ^ c);

   // Group terms
   assign x = &pt;
   assign y = gt[3]
            | (pt[3] & gt[2])
            | (pt[3] & pt[2] & gt[1])
            | (pt[3] & pt[2] & pt[1] & gt[0]);

endmodule

`default_nettype wire

// ==== source/alu_step_top.sv ====
// ALU step top level
// Input buffer, function block and output register on plain handshake ports

`timescale 1ns/1ps
`default_nettype none

module alu_step_top import alu_pkg::*; (
   input  logic                 clk,
   input  logic                 rst,
   input  logic                 cmd_req,
   input  logic [alu_width-1:0] cmd_a,
   input  logic [alu_width-1:0] cmd_m,
   input  logic [alu_width-1:0] cmd_q,
   input  logic [13:0]          cmd_ir,
   input  logic                 cmd_is_alu,
   input  logic                 cmd_is_jump,
   input  logic                 cmd_is_mul,
   input  logic                 cmd_is_div,
   output logic                 cmd_ack,
   output logic                 res_req,
   input  logic                 res_ack,
   output logic [alu_width-1:0] res_word,
   output logic                 res_carry
);

   alu_cmd_t cmd_data;
   alu_res_t res;
   logic     res_valid;
   logic     res_ready;

   alu_op_if op_if ();

   assign cmd_data.a       = cmd_a;
   assign cmd_data.m       = cmd_m;
   assign cmd_data.q       = cmd_q;
   assign cmd_data.ir      = ir_low_t'(cmd_ir);
   assign cmd_data.is_alu  = cmd_is_alu;
   assign cmd_data.is_jump = cmd_is_jump;
   assign cmd_data.is_mul  = cmd_is_mul;
   assign cmd_data.is_div  = cmd_is_div;

   alu_cmd_in u_cmd_in (
      .clk(clk), .rst(rst), .cmd_req(cmd_req), .cmd_data(cmd_data),
      .cmd_ack(cmd_ack), .op(op_if)
   );

   alu_function u_function (
      .clk(clk), .rst(rst), .op(op_if),
      .res(res), .res_valid(res_valid), .res_ready(res_ready)
   );

   alu_result_out u_result_out (
      .clk(clk), .rst(rst), .res(res), .res_valid(res_valid), .res_ready(res_ready),
      .res_req(res_req), .res_ack(res_ack), .res_word(res_word), .res_carry(res_carry)
   );

endmodule

`default_nettype wire

// ==== source/carry_lookahead.sv ====
// 74182-style carry lookahead for four groups
// Inverted carries into the next three groups and group X/Y upward

`timescale 1ns/1ps
`default_nettype none

module carry_lookahead (
   input  logic [3:0] x,
   input  logic [3:0] y,
   input  logic       cin_n,
   output logic [2:0] cout_n,
   output logic       xout,
   output logic       yout
);

   logic c;

   assign c = ~cin_n;

   assign cout_n[0] = ~(y[0] | (x[0] & c));
   assign cout_n[1] = ~(y[1] | (x[1] & y[0]) | (x[1] & x[0] & c));
   assign cout_n[2] = ~(y[2] | (x[2] & y[1]) | (x[2] & x[1] & y[0])
                      | (x[2] & x[1] & x[0] & c));

   assign xout = &x;
   assign yout = y[3]
               | (x[3] & y[2])
               | (x[3] & x[2] & y[1])
               | (x[3] & x[2] & x[1] & y[0]);

endmodule

`default_nettype wire

// ==== testbench/alu_checker.sv ====
// ALU step checker
// Queues commands as they are acknowledged, predicts each result with a
// 74181 reference model and compares it when the result is offered

`timescale 1ns/1ps

module alu_checker import alu_pkg::*; (
   input  logic        clk,
   input  logic        rst,
   input  logic        cmd_ack,
   input  logic [31:0] cmd_a,
   input  logic [31:0] cmd_m,
   input  logic [31:0] cmd_q,
   input  logic [13:0] cmd_ir,
   input  logic        cmd_is_alu,
   input  logic        cmd_is_jump,
   input  logic        cmd_is_mul,
   input  logic        cmd_is_div,
   input  logic        res_req,
   input  logic [31:0] res_word,
   input  logic        res_carry,
   output int          accepted_count,
   output int          result_count,
   output int          error_count,
   output int          pending_count
);

   alu_cmd_t pending [$];
   logic     ack_q;
   logic     req_q;

   function automatic alu_res_t expected_result(input alu_cmd_t c);
      logic [13:0] irb;
      logic [31:0] a;
      logic [31:0] b;
      logic        force_add;
      logic        force_sub;
      logic        last_pos;
      logic [3:0]  s;
      logic        logic_mode;
      logic        cin;
      logic [31:0] x;
      logic [31:0] y;
      logic [31:0] lf;
      logic [32:0] total;
      logic [31:0] f;
      logic [1:0]  osel;
      alu_res_t    r;
      irb = c.ir;
      a = c.a;
      b = c.m;
      // Multiply adds when Q0 is set, both forced means pass A
      force_add = c.is_mul;
      force_sub = (c.is_mul & ~c.q[0]) | c.is_jump;
      last_pos = c.q[0] | irb[6];
      // Negative A swaps the divide add and subtract terms
      if (c.is_div) begin
         if (c.a[31]) begin
            force_add = force_add | last_pos;
            force_sub = force_sub | irb[5] | ~last_pos;
         end else begin
            force_add = force_add | irb[5] | ~last_pos;
            force_sub = force_sub | last_pos;
         end
      end
      if (force_add && force_sub) begin
         s = 4'hf;
         logic_mode = 1'b1;
         cin = 1'b1;
      end else if (force_add) begin
         s = 4'h9;
         logic_mode = 1'b0;
         cin = 1'b0;
      end else if (force_sub) begin
         s = 4'h6;
         logic_mode = 1'b0;
         cin = ~c.is_jump;
      end else begin
         s = {irb[3], irb[4], ~irb[6], ~irb[5]};
         logic_mode = ~irb[7];
         cin = irb[2];
      end
      // Arithmetic rows as two addends
      case (s)
         4'h0: {x, y} = {a, 32'd0};
         4'h1: {x, y} = {a | b, 32'd0};
         4'h2: {x, y} = {a | ~b, 32'd0};
         4'h3: {x, y} = {32'hffff_ffff, 32'd0};
         4'h4: {x, y} = {a, a & ~b};
         4'h5: {x, y} = {a | b, a & ~b};
         4'h6: {x, y} = {a, ~b};
         4'h7: {x, y} = {a & ~b, 32'hffff_ffff};
         4'h8: {x, y} = {a, a & b};
         4'h9: {x, y} = {a, b};
         4'ha: {x, y} = {a | ~b, a & b};
         4'hb: {x, y} = {a & b, 32'hffff_ffff};
         4'hc: {x, y} = {a, a};
         4'hd: {x, y} = {a | b, a};
         4'he: {x, y} = {a | ~b, a};
         default: {x, y} = {a, 32'hffff_ffff};
      endcase
      case (s)
         4'h0: lf = ~a;
         4'h1: lf = ~(a | b);
         4'h2: lf = ~a & b;
         4'h3: lf = 32'd0;
         4'h4: lf = ~(a & b);
         4'h5: lf = ~b;
         4'h6: lf = a ^ b;
         4'h7: lf = a & ~b;
         4'h8: lf = ~a | b;
         4'h9: lf = ~(a ^ b);
         4'ha: lf = b;
         4'hb: lf = a & b;
         4'hc: lf = 32'hffff_ffff;
         4'hd: lf = a | ~b;
         4'he: lf = a | b;
         default: lf = a;
      endcase
      total = {1'b0, x} + {1'b0, y} + {32'd0, cin};
      f = logic_mode ? lf : total[31:0];
      osel = c.is_alu ? irb[13:12] : 2'd0;
      case (osel)
         2'd1: r.word = {f[30:0], 1'b0};
         2'd2: r.word = {total[32], f[31:1]};
         2'd3: r.word = {f[0], c.q[31:1]};
         default: r.word = f;
      endcase
      r.carry_out = total[32];
      return r;
   endfunction

   always @(posedge clk) begin
      alu_cmd_t c;
      alu_res_t want;
      if (rst) begin
         ack_q <= 1'b0;
         req_q <= 1'b0;
         accepted_count = 0;
         result_count = 0;
         error_count = 0;
      end else begin
         ack_q <= cmd_ack;
         req_q <= res_req;
         // Data still stable when the new ack is first seen
         if (cmd_ack && !ack_q) begin
            c.a = cmd_a;
            c.m = cmd_m;
            c.q = cmd_q;
            c.ir = cmd_ir;
            c.is_alu = cmd_is_alu;
            c.is_jump = cmd_is_jump;
            c.is_mul = cmd_is_mul;
            c.is_div = cmd_is_div;
            pending.push_back(c);
            accepted_count++;
         end
         if (res_req && !req_q) begin
            if (pending.size() == 0) begin
               $display("Result offered at %0t with no command pending", $time);
               error_count++;
            end else begin
               c = pending.pop_front();
               want = expected_result(c);
               if (res_word !== want.word || res_carry !== want.carry_out) begin
                  $display("[FAIL] %0t: result %0d is %h carry %b, expected %h carry %b",
                           $time, result_count, res_word, res_carry, want.word,
                           want.carry_out);
                  error_count++;
               end
               result_count++;
            end
         end
      end
      pending_count = pending.size();
   end

endmodule

// ==== testbench/tb_alu_step.sv ====
// ALU step testbench
// Drives random commands through the input handshake and takes results
// with random res_ack delays while alu_checker compares them

`timescale 1ns/1ps

module tb_alu_step import alu_pkg::*; ();

   localparam int num_cmds   = 200;
   localparam int wait_limit = 300;

   logic        clk;
   logic        rst;
   logic        cmd_req;
   logic [31:0] cmd_a;
   logic [31:0] cmd_m;
   logic [31:0] cmd_q;
   logic [13:0] cmd_ir;
   logic        cmd_is_alu;
   logic        cmd_is_jump;
   logic        cmd_is_mul;
   logic        cmd_is_div;
   logic        cmd_ack;
   logic        res_req;
   logic        res_ack;
   logic [31:0] res_word;
   logic        res_carry;

   int       seed;
   int       other_errors;
   logic     aborted;
   int       accepted_count;
   int       result_count;
   int       error_count;
   int       pending_count;
   alu_cmd_t cmds [num_cmds];
   int       ack_delay [num_cmds];

   always #5 clk = ~clk;

   alu_step_top dut0 (
      .clk(clk), .rst(rst), .cmd_req(cmd_req), .cmd_a(cmd_a), .cmd_m(cmd_m),
      .cmd_q(cmd_q), .cmd_ir(cmd_ir), .cmd_is_alu(cmd_is_alu), .cmd_is_jump(cmd_is_jump),
      .cmd_is_mul(cmd_is_mul), .cmd_is_div(cmd_is_div), .cmd_ack(cmd_ack),
      .res_req(res_req), .res_ack(res_ack), .res_word(res_word), .res_carry(res_carry)
   );

   alu_checker u_checker (
      .clk(clk), .rst(rst), .cmd_ack(cmd_ack), .cmd_a(cmd_a), .cmd_m(cmd_m),
      .cmd_q(cmd_q), .cmd_ir(cmd_ir), .cmd_is_alu(cmd_is_alu), .cmd_is_jump(cmd_is_jump),
      .cmd_is_mul(cmd_is_mul), .cmd_is_div(cmd_is_div), .res_req(res_req),
      .res_word(res_word), .res_carry(res_carry), .accepted_count(accepted_count),
      .result_count(result_count), .error_count(error_count),
      .pending_count(pending_count)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus tables drawn before the run so both processes share one stream

   task automatic build_commands();
      logic [31:0] r;
      alu_cmd_t    c;
      for (int i = 0; i < num_cmds; i++) begin
         c.a = $random(seed);
         c.m = $random(seed);
         c.q = $random(seed);
         r = $random(seed);
         c.ir = r[13:0];
         c.is_alu = 1'b1;
         c.is_jump = 1'b0;
         c.is_mul = 1'b0;
         c.is_div = 1'b0;
         case (r[18:16])
            3'd3: begin
               c.is_mul = 1'b1;
               c.is_alu = r[20];
            end
            3'd4, 3'd5: begin
               c.is_div = 1'b1;
               c.is_alu = r[20];
            end
            3'd6: begin
               c.is_jump = 1'b1;
               c.is_alu = r[20];
            end
            3'd7: c.is_alu = 1'b0;
            default: ;
         endcase
         cmds[i] = c;
         ack_delay[i] = {28'd0, r[27:24]};
      end
   endtask

   task automatic wait_cmd_ack(input logic level, input int idx);
      int n;
      n = 0;
      while (cmd_ack !== level && n < wait_limit && !aborted) begin
         @(negedge clk);
         n++;
      end
      if (cmd_ack !== level && !aborted) begin
         $display("Timeout at %0t: cmd_ack did not go to %b for command %0d",
                  $time, level, idx);
         other_errors++;
         aborted = 1'b1;
      end
   endtask

   task automatic wait_res_req(input logic level, input int idx);
      int n;
      n = 0;
      while (res_req !== level && n < wait_limit && !aborted) begin
         @(negedge clk);
         n++;
      end
      if (res_req !== level && !aborted) begin
         $display("Timeout at %0t: res_req did not go to %b for result %0d",
                  $time, level, idx);
         other_errors++;
         aborted = 1'b1;
      end
   endtask

   task automatic send_commands();
      for (int i = 0; i < num_cmds; i++) begin
         if (aborted)
            break;
         @(negedge clk);
         cmd_a = cmds[i].a;
         cmd_m = cmds[i].m;
         cmd_q = cmds[i].q;
         cmd_ir = cmds[i].ir;
         cmd_is_alu = cmds[i].is_alu;
         cmd_is_jump = cmds[i].is_jump;
         cmd_is_mul = cmds[i].is_mul;
         cmd_is_div = cmds[i].is_div;
         cmd_req = 1'b1;
         wait_cmd_ack(1'b1, i);
         cmd_req = 1'b0;
         wait_cmd_ack(1'b0, i);
      end
   endtask

   // Slow ack holds the output register and backs up the pipeline
   task automatic take_results();
      for (int i = 0; i < num_cmds; i++) begin
         if (aborted)
            break;
         wait_res_req(1'b1, i);
         repeat (ack_delay[i]) @(negedge clk);
         res_ack = 1'b1;
         wait_res_req(1'b0, i);
         res_ack = 1'b0;
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      rst = 1'b1;
      cmd_req = 1'b0;
      cmd_a = '0;
      cmd_m = '0;
      cmd_q = '0;
      cmd_ir = '0;
      cmd_is_alu = 1'b0;
      cmd_is_jump = 1'b0;
      cmd_is_mul = 1'b0;
      cmd_is_div = 1'b0;
      res_ack = 1'b0;
      seed = 59532;
      other_errors = 0;
      aborted = 1'b0;
      build_commands();
      repeat (10) @(negedge clk);
      rst = 1'b0;
      @(negedge clk);
      if (cmd_ack !== 1'b0 || res_req !== 1'b0) begin
         $display("[FAIL] %0t: cmd_ack is %b and res_req is %b after reset, expected both low",
                  $time, cmd_ack, res_req);
         other_errors++;
      end
      fork
         send_commands();
         take_results();
      join
      repeat (2) @(posedge clk);
      if (accepted_count != num_cmds) begin
         $display("Only %0d of %0d commands were accepted", accepted_count, num_cmds);
         other_errors++;
      end
      if (result_count != num_cmds) begin
         $display("Only %0d of %0d results were checked", result_count, num_cmds);
         other_errors++;
      end
      if (pending_count != 0) begin
         $display("%0d commands never produced a result", pending_count);
         other_errors++;
      end
      $display("Accepted %0d, checked %0d, mismatches %0d, other errors %0d",
               accepted_count, result_count, error_count, other_errors);
      if (error_count == 0 && other_errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
